// ==== verilog/obi_pkg.sv ====
// Data bus types: widths, address, data, byte enable, protection, request and response structs
package obi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte address width on the data bus
  localparam int unsigned OBI_AW = 32;
  // Data word width, one word per transfer
  localparam int unsigned OBI_DW = 32;
  // One enable per byte lane
  localparam int unsigned OBI_BW = OBI_DW / 8;

  // Byte address, always word aligned when it leaves the unit
  typedef logic [OBI_AW-1:0] obi_addr_t;
  // Bus data word
  typedef logic [OBI_DW-1:0] obi_data_t;
  // Byte lane enables
  typedef logic [OBI_BW-1:0] obi_be_t;
  // Bit 0 marks a data access, bits 2:1 hold the privilege level
  typedef logic [2:0]        obi_prot_t;

  ////////////////////////////////////////////////////////////////////////////
  // Channel structs
  ////////////////////////////////////////////////////////////////////////////

  // Address phase, held stable from req until gnt
  typedef struct packed {
    logic      req;
    obi_addr_t addr;
    logic      we;
    obi_be_t   be;
    obi_data_t wdata;
    obi_prot_t prot;
  } obi_req_t;

  // Grant for the address phase, rvalid and rdata for the response phase
  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    obi_data_t rdata;
  } obi_rsp_t;

endpackage

// ==== verilog/lsu_pkg.sv ====
// Load/store instruction types: size and privilege enums, core request, stage structs, write-back
package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////

  // Access size as decoded by the core
  typedef enum logic [1:0] {
    LSU_BYTE = 2'd0,
    LSU_HALF = 2'd1,
    LSU_WORD = 2'd2
  } lsu_size_e;

  // Privilege of the instruction, copied into prot bits 2:1
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  // Byte offset of an access inside its first word
  typedef logic [1:0] lsu_boff_t;

  // Request from the execute stage, valid with the req_valid strobe
  typedef struct packed {
    logic              is_store;
    lsu_size_e         size;
    logic              is_signed;
    obi_pkg::obi_addr_t base;
    obi_pkg::obi_addr_t offset;
    obi_pkg::obi_data_t wdata;
    priv_e             priv;
  } lsu_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // Inter-stage structs
  ////////////////////////////////////////////////////////////////////////////

  // One word transfer from the address stage to the bus stage
  // The tail fields are not driven on the bus but become the response context
  typedef struct packed {
    obi_pkg::obi_addr_t addr;
    logic              we;
    obi_pkg::obi_be_t   be;
    obi_pkg::obi_data_t wdata;
    obi_pkg::obi_prot_t prot;
    lsu_boff_t         boff;
    lsu_size_e         size;
    logic              is_signed;
    // Set on a single transfer or on the second half of a split
    logic              last;
    logic              is_split;
  } lsu_xfer_t;

  // Travels with each granted transfer until its rvalid
  typedef struct packed {
    lsu_boff_t boff;
    lsu_size_e size;
    logic      is_signed;
    logic      is_store;
    logic      is_split;
    logic      last;
  } lsu_ctx_t;

  // Write-back result, one per load or store
  typedef struct packed {
    obi_pkg::obi_data_t rdata;
    logic              is_store;
    logic              misaligned;
  } lsu_wb_t;

endpackage

// ==== verilog/lsu_addr_stage.sv ====
// Address stage: effective address, alignment check, split FSM, lane-aligned write data
`timescale 1ns/1ps

module lsu_addr_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              kill_i,
  input  logic              take_i,
  output logic              ready_o,
  output logic              xfer_valid_o,
  output lsu_pkg::lsu_xfer_t xfer_o,
  output logic              busy_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  // Idle, presenting the first or only half, presenting the second half
  typedef enum logic [1:0] {S_IDLE, S_FIRST, S_SECOND} state_e;

  state_e    state_q, state_d;
  obi_addr_t addr_q;
  lsu_size_e size_q;
  logic      is_store_q;
  logic      is_signed_q;
  obi_data_t wdata_q;
  priv_e     priv_q;
  obi_prot_t prot_first_q;

  lsu_boff_t   boff;
  logic [3:0]  size_mask;
  logic [7:0]  be_wide;
  logic [63:0] wdata_wide;
  logic        split;
  logic        second;
  logic        accept;

  ////////////////////////////////////////////////////////////////////////////
  // Lane alignment over a two-word window
  ////////////////////////////////////////////////////////////////////////////

  assign boff = addr_q[1:0];

  always_comb begin
    case (size_q)
      LSU_BYTE: size_mask = 4'b0001;
      LSU_HALF: size_mask = 4'b0011;
      default:  size_mask = 4'b1111;
    endcase
  end

  // Upper four enables and upper data word belong to the next word address
  assign be_wide    = {4'b0000, size_mask} << boff;
  assign wdata_wide = {32'd0, wdata_q} << {boff, 3'b000};
  // Any enable in the upper word means the access crosses a word boundary
  assign split      = |be_wide[7:4];
  assign second     = (state_q == S_SECOND);

  always_comb begin
    xfer_o.addr      = {addr_q[31:2], 2'b00} + (second ? 32'd4 : 32'd0);
    xfer_o.we        = is_store_q;
    xfer_o.be        = second ? be_wide[7:4] : be_wide[3:0];
    xfer_o.wdata     = second ? wdata_wide[63:32] : wdata_wide[31:0];
    // Data access with the privilege of the instruction
    xfer_o.prot      = {priv_q, 1'b1};
    xfer_o.boff      = boff;
    xfer_o.size      = size_q;
    xfer_o.is_signed = is_signed_q;
    xfer_o.last      = second || !split;
    xfer_o.is_split  = split;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Split FSM
  ////////////////////////////////////////////////////////////////////////////

  // A kill withdraws the first half before it is granted
  assign xfer_valid_o = ((state_q == S_FIRST) && !kill_i) || second;
  // Free now, or freed by the grant of the final half in this cycle
  assign ready_o      = (state_q == S_IDLE) || (take_i && xfer_o.last);
  assign accept       = req_valid_i && ready_o;
  assign busy_o       = (state_q != S_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FIRST: begin
        if (kill_i) begin
          state_d = S_IDLE;
        end else if (take_i) begin
          state_d = split ? S_SECOND : S_IDLE;
        end
      end
      // The second half is committed and ignores kill
      S_SECOND: begin
        if (take_i) begin
          state_d = S_IDLE;
        end
      end
      default: ;
    endcase
    if (accept) begin
      state_d = S_FIRST;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Effective address is formed once, when the request is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q      <= req_i.base + req_i.offset;
      size_q      <= req_i.size;
      is_store_q  <= req_i.is_store;
      is_signed_q <= req_i.is_signed;
      wdata_q     <= req_i.wdata;
      priv_q      <= req_i.priv;
    end
    if ((state_q == S_FIRST) && take_i) begin
      prot_first_q <= xfer_o.prot;
    end
  end

  // Both halves of a split reach the bus with the same protection bits
  a_split_prot_equal :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (second && take_i) |-> (xfer_o.prot == prot_first_q))
      else $error("Protection differs between the halves of a split access");

  // The core strobes a request only while the stage can take it
  a_no_req_when_busy :
    assert property (@(posedge clk) disable iff (!rst_n)
                     req_valid_i |-> ready_o)
      else $error("Request strobed while the address stage was not ready");

endmodule

// ==== verilog/lsu_bus_stage.sv ====
// Bus stage: OBI request driver, outstanding-transfer counter and response context push
`timescale 1ns/1ps

module lsu_bus_stage #(
  parameter int unsigned DEPTH = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               xfer_valid_i,
  input  lsu_pkg::lsu_xfer_t xfer_i,
  input  logic               halt_i,
  output obi_pkg::obi_req_t  obi_req_o,
  input  obi_pkg::obi_rsp_t  obi_rsp_i,
  output logic               take_o,
  output logic               push_o,
  output lsu_pkg::lsu_ctx_t  ctx_o,
  output logic               busy_o
);

  // Counter wide enough to hold DEPTH itself
  localparam int unsigned CW = $clog2(DEPTH + 1);

  logic [CW-1:0] cnt_q;
  logic          hold_q;
  logic          can_issue;
  logic          granted;

  ////////////////////////////////////////////////////////////////////////////
  // Request
  ////////////////////////////////////////////////////////////////////////////

  // A request already on the bus keeps going, even under halt
  // A new one needs a free slot and no halt from execute
  assign can_issue = hold_q || ((cnt_q < CW'(DEPTH)) && !halt_i);

  always_comb begin
    obi_req_o.req   = xfer_valid_i && can_issue;
    obi_req_o.addr  = xfer_i.addr;
    obi_req_o.we    = xfer_i.we;
    obi_req_o.be    = xfer_i.be;
    obi_req_o.wdata = xfer_i.wdata;
    obi_req_o.prot  = xfer_i.prot;
  end

  assign granted = obi_req_o.req && obi_rsp_i.gnt;
  // Grant frees the address stage and queues the context in the same cycle
  assign take_o  = granted;
  assign push_o  = granted;

  always_comb begin
    ctx_o.boff      = xfer_i.boff;
    ctx_o.size      = xfer_i.size;
    ctx_o.is_signed = xfer_i.is_signed;
    ctx_o.is_store  = xfer_i.we;
    ctx_o.is_split  = xfer_i.is_split;
    ctx_o.last      = xfer_i.last;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      hold_q <= 1'b0;
    end else begin
      // Remember a request that is still waiting for its grant
      hold_q <= obi_req_o.req && !obi_rsp_i.gnt;
      case ({granted, obi_rsp_i.rvalid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign busy_o = (cnt_q != '0);

  // Never more transfers in flight than the response queue can hold
  a_cnt_max_depth :
    assert property (@(posedge clk) disable iff (!rst_n)
                     cnt_q <= CW'(DEPTH))
      else $error("Outstanding transfer count exceeds DEPTH");

  // Every rvalid answers a transfer granted in an earlier cycle
  a_no_spurious_rvalid :
    assert property (@(posedge clk) disable iff (!rst_n)
                     obi_rsp_i.rvalid |-> (cnt_q != '0))
      else $error("rvalid seen with no transfer outstanding");

  // Address phase payload holds while the request waits for its grant
  a_req_payload_stable :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (obi_req_o.req && !obi_rsp_i.gnt) ##1 obi_req_o.req
                     |-> $stable(obi_req_o))
      else $error("Bus payload changed while waiting for gnt");

endmodule

// ==== verilog/lsu_resp_stage.sv ====
// Response stage: context FIFO, split-half merge, sign/zero extension and write-back register
`timescale 1ns/1ps

module lsu_resp_stage #(
  parameter int unsigned DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_i,
  input  lsu_pkg::lsu_ctx_t ctx_i,
  input  obi_pkg::obi_rsp_t obi_rsp_i,
  output logic              wb_valid_o,
  output lsu_pkg::lsu_wb_t  wb_o,
  output logic              busy_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  localparam int unsigned CW = $clog2(DEPTH + 1);
  // A single-entry queue still gets a one-bit pointer
  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  lsu_ctx_t      fifo_q [DEPTH];
  logic [PW-1:0] wptr_q;
  logic [PW-1:0] rptr_q;
  logic [CW-1:0] cnt_q;
  obi_data_t     lo_q;
  lsu_wb_t       wb_q;
  logic          wb_valid_q;

  lsu_ctx_t    head;
  logic        pop;
  logic        finish;
  logic [63:0] merged;
  logic [63:0] shifted;
  obi_data_t   ext;
  lsu_wb_t     wb_d;

  ////////////////////////////////////////////////////////////////////////////
  // Context queue, popped by rvalid in grant order
  ////////////////////////////////////////////////////////////////////////////

  assign head   = fifo_q[rptr_q];
  assign pop    = obi_rsp_i.rvalid;
  assign finish = pop && head.last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= (wptr_q == PW'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PW'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      fifo_q[wptr_q] <= ctx_i;
    end
    // First half of a split waits here for its partner
    if (pop && !head.last) begin
      lo_q <= obi_rsp_i.rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Merge and extension
  ////////////////////////////////////////////////////////////////////////////

  // Low word first, so the byte offset shift lines the value up at bit 0
  assign merged  = head.is_split ? {obi_rsp_i.rdata, lo_q} : {32'd0, obi_rsp_i.rdata};
  assign shifted = merged >> {head.boff, 3'b000};

  always_comb begin
    case (head.size)
      LSU_BYTE: ext = {{24{head.is_signed && shifted[7]}}, shifted[7:0]};
      LSU_HALF: ext = {{16{head.is_signed && shifted[15]}}, shifted[15:0]};
      default:  ext = shifted[31:0];
    endcase
  end

  always_comb begin
    // Stores report completion with a zero value
    wb_d.rdata      = head.is_store ? '0 : ext;
    wb_d.is_store   = head.is_store;
    wb_d.misaligned = head.is_split;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= finish;
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      wb_q <= wb_d;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;
  // Stays high through the write-back pulse itself
  assign busy_o     = (cnt_q != '0) || wb_valid_q;

  // The bus stage must stop granting before the queue runs out of room
  a_queue_no_overflow :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (push_i && !pop) |-> (cnt_q < CW'(DEPTH)))
      else $error("Response context queue overflow");

endmodule

// ==== verilog/lsu_top.sv ====
// Load/store unit top: address, bus and response stages with the shared DEPTH parameter
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              halt_i,
  input  logic              kill_i,
  output logic              ready_o,
  output logic              busy_o,
  output logic              wb_valid_o,
  output lsu_pkg::lsu_wb_t  wb_o,
  output obi_pkg::obi_req_t obi_req_o,
  input  obi_pkg::obi_rsp_t obi_rsp_i
);
  import lsu_pkg::*;

  // Address stage to bus stage
  logic      xfer_valid;
  lsu_xfer_t xfer;
  logic      take;

  // Bus stage to response stage, one entry per grant
  logic      push;
  lsu_ctx_t  ctx;

  logic      addr_busy;
  logic      bus_busy;
  logic      resp_busy;

  lsu_addr_stage u_addr (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .kill_i       (kill_i),
    .take_i       (take),
    .ready_o      (ready_o),
    .xfer_valid_o (xfer_valid),
    .xfer_o       (xfer),
    .busy_o       (addr_busy)
  );

  lsu_bus_stage #(.DEPTH(DEPTH)) u_bus (
    .clk          (clk),
    .rst_n        (rst_n),
    .xfer_valid_i (xfer_valid),
    .xfer_i       (xfer),
    .halt_i       (halt_i),
    .obi_req_o    (obi_req_o),
    .obi_rsp_i    (obi_rsp_i),
    .take_o       (take),
    .push_o       (push),
    .ctx_o        (ctx),
    .busy_o       (bus_busy)
  );

  lsu_resp_stage #(.DEPTH(DEPTH)) u_resp (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (push),
    .ctx_i      (ctx),
    .obi_rsp_i  (obi_rsp_i),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o),
    .busy_o     (resp_busy)
  );

  // An access is somewhere in the unit from acceptance until its write-back
  assign busy_o = addr_busy || bus_busy || resp_busy;

endmodule

// ==== dv/tb_obi_mem.sv ====
// Behavioral OBI data memory with random grant and response delays for the testbench
`timescale 1ns/1ps

module tb_obi_mem #(
  parameter int unsigned MEM_BYTES = 1024
) (
  input  logic              clk,
  input  logic              rst_n,
  input  obi_pkg::obi_req_t obi_req_i,
  output obi_pkg::obi_rsp_t obi_rsp_o
);
  import obi_pkg::*;

  logic [7:0] mem [MEM_BYTES];
  integer     seed;
  logic [1:0] gnt_wait_q;
  logic [1:0] rsp_wait_q;
  logic       rvalid_q;
  obi_data_t  rdata_q;
  obi_data_t  rsp_q [$];
  obi_data_t  word;
  logic [9:0] idx;

  // Draws the next delay of 0 to 3 cycles
  function automatic logic [1:0] next_delay();
    integer r;
    r = $random(seed);
    return r[1:0];
  endfunction

  // Every byte gets a value that depends on its full 10-bit address
  initial begin
    seed = 32'hbee3_f3a4;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = i[7:0] ^ {i[9:8], i[9:8], i[9:8], i[9:8]} ^ 8'h5a;
    end
  end

  // Grant comes once the wait counter for the waiting request runs out
  assign obi_rsp_o.gnt    = obi_req_i.req && (gnt_wait_q == 2'd0);
  assign obi_rsp_o.rvalid = rvalid_q;
  assign obi_rsp_o.rdata  = rdata_q;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= 2'd0;
      rsp_wait_q <= 2'd0;
      rvalid_q   <= 1'b0;
      rdata_q    <= '0;
      rsp_q.delete();
    end else begin
      rvalid_q <= 1'b0;
      // Responses leave in grant order, the head only after its own wait
      if (rsp_q.size() > 0) begin
        if (rsp_wait_q == 2'd0) begin
          rvalid_q   <= 1'b1;
          rdata_q    <= rsp_q.pop_front();
          rsp_wait_q <= next_delay();
        end else begin
          rsp_wait_q <= rsp_wait_q - 2'd1;
        end
      end
      // The access is done at grant, so its response is at least one cycle later
      if (obi_req_i.req) begin
        if (gnt_wait_q == 2'd0) begin
          idx = obi_req_i.addr[9:0];
          for (int lane = 0; lane < 4; lane++) begin
            if (obi_req_i.we && obi_req_i.be[lane]) begin
              mem[idx + lane] = obi_req_i.wdata[8*lane +: 8];
            end
            word[8*lane +: 8] = mem[idx + lane];
          end
          rsp_q.push_back(word);
          gnt_wait_q <= next_delay();
        end else begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

// ==== dv/lsu_tb.sv ====
// Load/store unit testbench: stimulus table, memory mirror, compare tasks, watchdog, report
`timescale 1ns/1ps

module lsu_tb;
  import obi_pkg::*;
  import lsu_pkg::*;

  localparam logic [1:0] KILL_NONE  = 2'd0;
  localparam logic [1:0] KILL_EARLY = 2'd1;
  localparam logic [1:0] KILL_LATE  = 2'd2;

  // One table row, kill says whether and when execute withdraws the access
  typedef struct packed {
    logic       is_store;
    lsu_size_e  size;
    logic       is_signed;
    obi_addr_t  base;
    obi_addr_t  offset;
    obi_data_t  wdata;
    logic [1:0] kill;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  lsu_req_t  req;
  logic      halt;
  logic      kill;
  logic      ready;
  logic      busy;
  logic      wb_valid;
  lsu_wb_t   wb;
  obi_req_t  obi_req;
  obi_rsp_t  obi_rsp;

  row_t       rows [$];
  logic [7:0] mirror [1024];
  lsu_wb_t    exp_wb_q [$];
  obi_addr_t  exp_addr_q [$];
  obi_be_t    exp_be_q [$];
  obi_prot_t  exp_prot_q [$];

  int wb_errs;
  int xfer_errs;
  int level_errs;
  int other_errs;
  int pending;
  int outstanding;
  int grant_cnt;
  int start_cnt;

  lsu_top #(.DEPTH(2)) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .halt_i      (halt),
    .kill_i      (kill),
    .ready_o     (ready),
    .busy_o      (busy),
    .wb_valid_o  (wb_valid),
    .wb_o        (wb),
    .obi_req_o   (obi_req),
    .obi_rsp_i   (obi_rsp)
  );

  tb_obi_mem #(.MEM_BYTES(1024)) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .obi_req_i (obi_req),
    .obi_rsp_o (obi_rsp)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_wb(input lsu_wb_t got, input lsu_wb_t exp);
    if (got !== exp) begin
      wb_errs++;
      $display("Fail at %0t: write-back rdata %h store %b mis %b, expected %h %b %b",
               $time, got.rdata, got.is_store, got.misaligned,
               exp.rdata, exp.is_store, exp.misaligned);
    end
  endtask

  task automatic check_xfer(input obi_req_t got, input obi_addr_t addr,
                            input obi_be_t be, input obi_prot_t prot);
    if (got.addr !== addr || got.be !== be || got.prot !== prot) begin
      xfer_errs++;
      $display("Fail at %0t: bus addr %h be %b prot %b, expected %h %b %b",
               $time, got.addr, got.be, got.prot, addr, be, prot);
    end
  endtask

  task automatic check_level(input logic got_ready, input logic got_busy,
                             input logic exp_ready, input logic exp_busy);
    if (got_ready !== exp_ready || got_busy !== exp_busy) begin
      level_errs++;
      $display("Fail at %0t: ready %b busy %b, expected %b %b",
               $time, got_ready, got_busy, exp_ready, exp_busy);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic st, input lsu_size_e sz, input logic sgn,
                         input obi_addr_t base, input obi_addr_t off,
                         input obi_data_t wdata, input logic [1:0] k);
    row_t r;
    r.is_store  = st;
    r.size      = sz;
    r.is_signed = sgn;
    r.base      = base;
    r.offset    = off;
    r.wdata     = wdata;
    r.kill      = k;
    rows.push_back(r);
  endtask

  task automatic fill_table();
    // Aligned store then load, then every byte and half position of that word
    add_row(1, LSU_WORD, 0, 32'h100, 32'd0, 32'hdead_beef, KILL_NONE);
    add_row(0, LSU_WORD, 0, 32'h100, 32'd0, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 1, 32'h100, 32'd0, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 1, 32'h100, 32'd1, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 1, 32'h100, 32'd2, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 1, 32'h100, 32'd3, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 0, 32'h100, 32'd1, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 0, 32'h100, 32'd3, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 1, 32'h100, 32'd0, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 1, 32'h100, 32'd2, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 0, 32'h100, 32'd1, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 0, 32'h100, 32'd3, 32'h0, KILL_NONE);
    // Word accesses that cross a word boundary
    add_row(1, LSU_WORD, 0, 32'h1fc, 32'd5, 32'h1234_5678, KILL_NONE);
    add_row(0, LSU_WORD, 1, 32'h200, 32'd1, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 1, 32'h203, 32'd0, 32'h0, KILL_NONE);
    add_row(0, LSU_BYTE, 1, 32'h204, 32'd0, 32'h0, KILL_NONE);
    add_row(0, LSU_WORD, 0, 32'h220, 32'hffff_fffc, 32'h0, KILL_NONE);
    // Killed before the first grant, then proof that memory is untouched
    add_row(0, LSU_WORD, 0, 32'h104, 32'd0, 32'h0, KILL_EARLY);
    add_row(1, LSU_HALF, 0, 32'h107, 32'd0, 32'h0000_aaaa, KILL_EARLY);
    add_row(0, LSU_WORD, 0, 32'h104, 32'd0, 32'h0, KILL_NONE);
    // Kill after the first half is granted must not stop the second
    add_row(0, LSU_WORD, 0, 32'h300, 32'd6, 32'h0, KILL_LATE);
    add_row(1, LSU_BYTE, 0, 32'h3ff, 32'd0, 32'h0000_0080, KILL_NONE);
    add_row(0, LSU_BYTE, 1, 32'h3ff, 32'd0, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 0, 32'h3fe, 32'd0, 32'h0, KILL_NONE);
    add_row(1, LSU_HALF, 0, 32'h302, 32'd1, 32'h0000_c3a5, KILL_LATE);
    add_row(0, LSU_WORD, 0, 32'h300, 32'd3, 32'h0, KILL_NONE);
    add_row(0, LSU_HALF, 1, 32'h302, 32'd1, 32'h0, KILL_NONE);
  endtask

  // Builds the expected transfers and result byte by byte from the mirror
  task automatic expect_row(input row_t r, input obi_prot_t prot);
    obi_addr_t ea;
    obi_addr_t ba;
    int        nbytes;
    obi_be_t   be0;
    obi_be_t   be1;
    obi_data_t val;
    lsu_wb_t   exp;
    ea     = r.base + r.offset;
    nbytes = (r.size == LSU_BYTE) ? 1 : (r.size == LSU_HALF) ? 2 : 4;
    be0    = '0;
    be1    = '0;
    val    = '0;
    for (int i = 0; i < nbytes; i++) begin
      ba = ea + i;
      if (ba[31:2] == ea[31:2]) be0[ba[1:0]] = 1'b1;
      else be1[ba[1:0]] = 1'b1;
      if (r.is_store) mirror[ba[9:0]] = r.wdata[8*i +: 8];
      else val[8*i +: 8] = mirror[ba[9:0]];
    end
    // Sign bit of the loaded value fills the upper bits
    if (!r.is_store && r.is_signed && val[8*nbytes-1]) begin
      for (int j = 8 * nbytes; j < 32; j++) begin
        val[j] = 1'b1;
      end
    end
    exp_addr_q.push_back({ea[31:2], 2'b00});
    exp_be_q.push_back(be0);
    exp_prot_q.push_back(prot);
    if (be1 != '0) begin
      exp_addr_q.push_back({ea[31:2], 2'b00} + 32'd4);
      exp_be_q.push_back(be1);
      exp_prot_q.push_back(prot);
    end
    exp.rdata      = r.is_store ? '0 : val;
    exp.is_store   = r.is_store;
    exp.misaligned = (be1 != '0);
    exp_wb_q.push_back(exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled mid-way between the falling and the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    #5;
    if (rst_n) begin
      if (obi_rsp.rvalid) begin
        if (outstanding == 0) begin
          other_errs++;
          $display("rvalid at %0t with no transfer outstanding", $time);
        end else begin
          outstanding--;
        end
      end
      if (obi_req.req && obi_rsp.gnt) begin
        grant_cnt++;
        outstanding++;
        if (exp_addr_q.size() == 0) begin
          other_errs++;
          $display("Bus grant at %0t with no transfer expected", $time);
        end else begin
          check_xfer(obi_req, exp_addr_q.pop_front(), exp_be_q.pop_front(),
                     exp_prot_q.pop_front());
        end
      end
      if (outstanding > 2) begin
        other_errs++;
        $display("More than two transfers outstanding at %0t", $time);
      end
      if (pending > 0 && !busy) begin
        other_errs++;
        $display("busy_o low at %0t while an access is in flight", $time);
      end
      if (wb_valid) begin
        if (exp_wb_q.size() == 0) begin
          other_errs++;
          $display("Write-back at %0t with no access expected", $time);
        end else begin
          check_wb(wb, exp_wb_q.pop_front());
          pending--;
        end
      end
    end
  end

  // Bounds the run by the table length, with room for reset
  initial begin
    #1;
    #(rows.size() * 20 * 20 + 200);
    $display("Watchdog expired at %0t before all accesses completed", $time);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    halt        = 1'b0;
    kill        = 1'b0;
    wb_errs     = 0;
    xfer_errs   = 0;
    level_errs  = 0;
    other_errs  = 0;
    pending     = 0;
    outstanding = 0;
    grant_cnt   = 0;
    for (int i = 0; i < 1024; i++) begin
      mirror[i] = i[7:0] ^ {i[9:8], i[9:8], i[9:8], i[9:8]} ^ 8'h5a;
    end
    fill_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_level(ready, busy, 1'b1, 1'b0);
    if (obi_req.req !== 1'b0 || wb_valid !== 1'b0) begin
      other_errs++;
      $display("Bus request or write-back active right after reset");
    end

    foreach (rows[n]) begin
      while (!ready) @(negedge clk);
      req.is_store  = rows[n].is_store;
      req.size      = rows[n].size;
      req.is_signed = rows[n].is_signed;
      req.base      = rows[n].base;
      req.offset    = rows[n].offset;
      req.wdata     = rows[n].wdata;
      // Odd rows run in machine mode so both prot encodings appear
      req.priv      = n[0] ? PRIV_M : PRIV_U;
      if (rows[n].kill != KILL_EARLY) begin
        expect_row(rows[n], n[0] ? 3'b111 : 3'b001);
      end
      req_valid = 1'b1;
      @(negedge clk);
      req_valid = 1'b0;
      if (rows[n].kill == KILL_EARLY) begin
        kill = 1'b1;
        @(negedge clk);
        kill = 1'b0;
      end else begin
        pending++;
        // Every grant of an earlier row has been counted by now
        start_cnt = grant_cnt;
        if (rows[n].kill == KILL_LATE) begin
          while (grant_cnt == start_cnt) @(negedge clk);
          kill = 1'b1;
          @(negedge clk);
          kill = 1'b0;
        end else if (n % 4 == 3) begin
          // Halt from execute keeps the first half off the bus
          halt = 1'b1;
          repeat (2) begin
            @(negedge clk);
            if (obi_req.req !== 1'b0) begin
              other_errs++;
              $display("Bus request at %0t while halt was high", $time);
            end
          end
          halt = 1'b0;
        end
      end
    end

    while (pending > 0) @(negedge clk);
    repeat (3) @(negedge clk);
    check_level(ready, busy, 1'b1, 1'b0);
    if (exp_addr_q.size() != 0) begin
      other_errs++;
      $display("%0d expected bus transfers never granted", exp_addr_q.size());
    end

    $display("Errors: write-back %0d, transfer %0d, level %0d, other %0d",
             wb_errs, xfer_errs, level_errs, other_errs);
    if (wb_errs + xfer_errs + level_errs + other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/obi_pkg.sv
verilog/lsu_pkg.sv
verilog/lsu_addr_stage.sv
verilog/lsu_bus_stage.sv
verilog/lsu_resp_stage.sv
verilog/lsu_top.sv
dv/tb_obi_mem.sv
dv/lsu_tb.sv

// ==== run_lsu_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator, runs it and scans the log.
# Exit status is 0 only when the run finished without a reported failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module lsu_tb \
  --Mdir obj_dir -o lsu_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; tail -n 40 build.log; exit 1; }

./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log \
  && { echo "Failure reported in sim.log"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
  || { echo "Run ended without a final report"; exit 1; }

exit 0
